/* Makefile */
TB_TOP = tinyCpuTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f tinyCpu.f --top-module $(TB_TOP)

# the log decides pass or fail
run: build
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f tinyCpu.f --top-module tinyCpu

clean:
	rm -rf obj_dir sim.log

/* hw/alu.sv */
module alu (
    input  corePkg::aluOpT aluOp,
    input  corePkg::wordT  operandA,
    input  corePkg::wordT  operandB,
    output corePkg::wordT  result,
    output logic           zero
);

    import corePkg::*;

    // plain wraparound arithmetic, no carry or overflow out
    always_comb begin
        case (aluOp)
            ALU_ADD   : result = operandA + operandB;
            ALU_SUB   : result = operandA - operandB;
            ALU_AND   : result = operandA & operandB;
            ALU_OR    : result = operandA | operandB;
            ALU_XOR   : result = operandA ^ operandB;
            // used by LDI to load the immediate
            ALU_PASSB : result = operandB;
            default   : result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hw/corePkg.sv */
`include "core_macros.svh"

package corePkg;

    // one datapath word
    typedef logic [`DATA_WIDTH-1:0] wordT;

    // register select, wide enough for the whole register file
    typedef logic [$clog2(`REG_COUNT)-1:0] regIndexT;

    // operations the ALU knows
    // ALU_PASSB forwards operand B, which is how LDI loads a constant
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASSB
    } aluOpT;

endpackage

/* hw/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// width of one data word and of every register
`define DATA_WIDTH 16

// program counter width, also the ROM address width
`define ROM_ADDR_WIDTH 10

// size of the register file
`define REG_COUNT 16

// credits held by the output port right after reset
// any value from 1 to 15 fits the 4-bit counter
`define OUT_CREDITS 2

`endif

/* hw/creditPort.sv */
`include "core_macros.svh"

module creditPort (
    input  logic          clock,
    input  logic          reset,
    input  logic          send,
    input  corePkg::wordT sendData,
    input  logic          creditReturn,
    output logic          stall,
    output corePkg::wordT outData,
    output logic          outValid
);

    // 4 bits hold up to 15 credits
    logic [3:0] creditCount;
    logic       canSend;

    assign canSend = send && (creditCount != '0);
    // out of credits, the OUT has to wait
    assign stall   = send && (creditCount == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            creditCount <= 4'(`OUT_CREDITS);
            outValid    <= 1'b0;
        end else begin
            // one-cycle valid per value sent
            outValid <= canSend;
            case ({canSend, creditReturn})
                2'b10   : creditCount <= creditCount - 4'd1;
                2'b01   : creditCount <= creditCount + 4'd1;
                // both or neither, count stays
                default : creditCount <= creditCount;
            endcase
        end
    end

    // data only matters while outValid is high
    always_ff @(posedge clock) begin
        if (canSend) begin
            outData <= sendData;
        end
    end

endmodule

/* hw/fetchControl.sv */
`include "core_macros.svh"

module fetchControl (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       isBranch,
    input  logic                       isHalt,
    input  logic                       stall,
    input  corePkg::wordT              branchValue,
    input  corePkg::wordT              offset,
    output logic [`ROM_ADDR_WIDTH-1:0] pc,
    output logic                       halted
);

    logic                       branchTaken;
    logic [`ROM_ADDR_WIDTH-1:0] branchTarget;
    logic [`ROM_ADDR_WIDTH-1:0] nextPc;

    // BNZ goes when the tested register is nonzero
    assign branchTaken  = isBranch && (branchValue != '0);
    // offset is sign-extended, so the low bits wrap correctly
    assign branchTarget = pc + offset[`ROM_ADDR_WIDTH-1:0];

    always_comb begin
        if (stall || isHalt || halted) begin
            nextPc = pc;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pc + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            pc <= nextPc;
            // sticky until the next reset
            if (isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* hw/instructionDecoder.sv */
`include "core_macros.svh"

module instructionDecoder (
    input  isaPkg::instructionT instruction,
    output corePkg::regIndexT   rdSel,
    output corePkg::regIndexT   raSel,
    output corePkg::aluOpT      aluOp,
    output corePkg::wordT       immValue,
    output logic                useImm,
    output logic                regWrite,
    output logic                isBranch,
    output logic                isOut,
    output logic                isHalt
);

    import isaPkg::*;
    import corePkg::*;

    wordT signedImm;
    wordT unsignedImm;

    // register fields are in the same place for every format
    assign rdSel = instruction.regForm.rd;
    assign raSel = instruction.regForm.ra;

    // ADDI and BNZ take a signed byte, LDI an unsigned one
    assign signedImm   = {{(`DATA_WIDTH-8){instruction.immForm.imm[7]}}, instruction.immForm.imm};
    assign unsignedImm = {{(`DATA_WIDTH-8){1'b0}}, instruction.immForm.imm};

    always_comb begin
        aluOp    = ALU_ADD;
        immValue = '0;
        useImm   = 1'b0;
        regWrite = 1'b0;
        isBranch = 1'b0;
        isOut    = 1'b0;
        isHalt   = 1'b0;
        case (instruction.regForm.opcode)
            OP_ALU : begin
                regWrite = 1'b1;
                case (instruction.regForm.func)
                    FUNC_ADD : aluOp = ALU_ADD;
                    FUNC_SUB : aluOp = ALU_SUB;
                    FUNC_AND : aluOp = ALU_AND;
                    FUNC_OR  : aluOp = ALU_OR;
                    FUNC_XOR : aluOp = ALU_XOR;
                    // undefined function codes write nothing
                    default  : regWrite = 1'b0;
                endcase
            end
            OP_ADDI : begin
                aluOp    = ALU_ADD;
                immValue = signedImm;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            OP_LDI : begin
                aluOp    = ALU_PASSB;
                immValue = unsignedImm;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            // branch offset is relative to the BNZ itself
            OP_BNZ  : begin
                immValue = signedImm;
                isBranch = 1'b1;
            end
            OP_OUT  : isOut = 1'b1;
            OP_HALT : isHalt = 1'b1;
            default : ;
        endcase
    end

endmodule

/* hw/instructionRom.sv */
`include "core_macros.svh"

module instructionRom (
    input  logic [`ROM_ADDR_WIDTH-1:0] address,
    output isaPkg::instructionT        instruction
);

    logic [15:0] romWord;

    // program table, read combinationally
    always_comb begin : romTable
        case (address)
            // setup: r1 = current term, r2 = previous term, r3 = loop count
            10'h000 : romWord = 16'hC101;
            10'h001 : romWord = 16'hC200;
            10'h002 : romWord = 16'hC30A;
            // fib loop, send the current term first
            10'h003 : romWord = 16'hE100;
            // r4 = copy of r1
            10'h004 : romWord = 16'hC400;
            10'h005 : romWord = 16'h0410;
            // r1 = r1 + r2, then r2 = old r1
            10'h006 : romWord = 16'h0120;
            10'h007 : romWord = 16'hC200;
            10'h008 : romWord = 16'h0240;
            // count down and branch back by 7 to 0x003
            10'h009 : romWord = 16'h33FF;
            10'h00A : romWord = 16'hB3F9;
            // r2 now holds the tenth term, 55
            // AND with 0x0F
            10'h00B : romWord = 16'hC50F;
            10'h00C : romWord = 16'h0522;
            10'h00D : romWord = 16'hE500;
            // OR with 0x80
            10'h00E : romWord = 16'hC580;
            10'h00F : romWord = 16'h0523;
            10'h010 : romWord = 16'hE500;
            // XOR with 0xFF, LDI zero-extends so only the low byte flips
            10'h011 : romWord = 16'hC5FF;
            10'h012 : romWord = 16'h0524;
            10'h013 : romWord = 16'hE500;
            // r2 = r2 - 5
            10'h014 : romWord = 16'hC505;
            10'h015 : romWord = 16'h0251;
            10'h016 : romWord = 16'hE200;
            // stop here for good
            10'h017 : romWord = 16'h2000;
            // zero is ADD r0,r0 and does nothing
            default : romWord = 16'h0000;
        endcase
    end

    assign instruction = romWord;

endmodule

/* hw/isaPkg.sv */
package isaPkg;

    // top nibble of every instruction word
    typedef enum logic [3:0] {
        OP_ALU  = 4'h0,
        OP_HALT = 4'h2,
        OP_ADDI = 4'h3,
        OP_BNZ  = 4'hB,
        OP_LDI  = 4'hC,
        OP_OUT  = 4'hE
    } opcodeT;

    // low nibble of a register-form word selects the operation
    typedef enum logic [3:0] {
        FUNC_ADD = 4'h0,
        FUNC_SUB = 4'h1,
        FUNC_AND = 4'h2,
        FUNC_OR  = 4'h3,
        FUNC_XOR = 4'h4
    } aluFuncT;

    // register form: rd = rd op ra
    typedef struct packed {
        opcodeT     opcode;
        logic [3:0] rd;
        logic [3:0] ra;
        aluFuncT    func;
    } regFormT;

    // immediate form, used by LDI, ADDI, BNZ and OUT
    // OUT and HALT ignore the immediate byte
    typedef struct packed {
        opcodeT     opcode;
        logic [3:0] rd;
        logic [7:0] imm;
    } immFormT;

    // opcode and rd sit in the same bits in both views,
    // so the decoder can read them through either member
    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instructionT;

endpackage

/* hw/registerFile.sv */
`include "core_macros.svh"

module registerFile (
    input  logic              clock,
    input  logic              reset,
    input  corePkg::regIndexT rdSel,
    input  corePkg::regIndexT raSel,
    input  logic              writeEnable,
    input  corePkg::wordT     writeData,
    output corePkg::wordT     rdValue,
    output corePkg::wordT     raValue
);

    import corePkg::*;

    wordT regs [`REG_COUNT];

    // writes land on rdSel, r0 is never written so it stays zero
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rdSel != '0)) begin
            regs[rdSel] <= writeData;
        end
    end

    // asynchronous reads
    assign rdValue = regs[rdSel];
    assign raValue = regs[raSel];

endmodule

/* hw/tinyCpu.sv */
`include "core_macros.svh"

module tinyCpu (
    input  logic          clock,
    input  logic          reset,
    input  logic          creditReturn,
    output corePkg::wordT outData,
    output logic          outValid,
    output logic          halted
);

    import isaPkg::*;
    import corePkg::*;

    logic [`ROM_ADDR_WIDTH-1:0] pc;
    instructionT                instruction;
    regIndexT                   rdSel;
    regIndexT                   raSel;
    aluOpT                      aluOp;
    wordT                       immValue;
    logic                       useImm;
    logic                       regWrite;
    logic                       isBranch;
    logic                       isOut;
    logic                       isHalt;
    wordT                       rdValue;
    wordT                       raValue;
    wordT                       operandB;
    wordT                       aluResult;
    logic                       stall;

    fetchControl u_fetchControl (
        .clock       (clock),
        .reset       (reset),
        .isBranch    (isBranch),
        .isHalt      (isHalt),
        .stall       (stall),
        .branchValue (rdValue),
        .offset      (immValue),
        .pc          (pc),
        .halted      (halted)
    );

    instructionRom u_instructionRom (
        .address     (pc),
        .instruction (instruction)
    );

    instructionDecoder u_instructionDecoder (
        .instruction (instruction),
        .rdSel       (rdSel),
        .raSel       (raSel),
        .aluOp       (aluOp),
        .immValue    (immValue),
        .useImm      (useImm),
        .regWrite    (regWrite),
        .isBranch    (isBranch),
        .isOut       (isOut),
        .isHalt      (isHalt)
    );

    registerFile u_registerFile (
        .clock       (clock),
        .reset       (reset),
        .rdSel       (rdSel),
        .raSel       (raSel),
        .writeEnable (regWrite),
        .writeData   (aluResult),
        .rdValue     (rdValue),
        .raValue     (raValue)
    );

    // immediate forms replace the second register operand
    assign operandB = useImm ? immValue : raValue;

    // zero flag has no consumer, BNZ tests rdValue in fetch
    alu u_alu (
        .aluOp    (aluOp),
        .operandA (rdValue),
        .operandB (operandB),
        .result   (aluResult),
        .zero     ()
    );

    // OUT sends the destination register
    creditPort u_creditPort (
        .clock        (clock),
        .reset        (reset),
        .send         (isOut),
        .sendData     (rdValue),
        .creditReturn (creditReturn),
        .stall        (stall),
        .outData      (outData),
        .outValid     (outValid)
    );

endmodule

/* tb/tinyCpuTb.sv */
`include "core_macros.svh"

module tinyCpuTb;

    timeunit 1ns;
    timeprecision 1ps;

    import corePkg::*;

    localparam int ROWS = 14;
    localparam int LONG_DELAY = 20;
    // worst case per pass with every row waiting on a long credit return
    localparam int CYCLE_LIMIT = ROWS * (8 + LONG_DELAY) + 200;
    localparam int HALT_WAIT = 20;
    localparam int QUIET_CYCLES = 50;

    logic clock;
    logic reset;
    logic creditReturn;
    wordT outData;
    logic outValid;
    logic halted;

    // expected value and credit-return delay per row
    wordT expectedValue [ROWS];
    int   returnDelay [ROWS];

    logic [7:0] lfsrState;
    int         pendingDue [$];
    int         cycleCount;
    int         passCycles;
    int         valuesSeen;
    int         creditsReturned;
    int         errorCount;
    int         testStartErrors;
    int         testsPassed;
    int         testsFailed;

    tinyCpu u_dut (
        .clock        (clock),
        .reset        (reset),
        .creditReturn (creditReturn),
        .outData      (outData),
        .outValid     (outValid),
        .halted       (halted)
    );

    always #4 clock = ~clock;

    // counts cycles of the current pass and clears on every reset
    always @(posedge clock) begin
        if (reset) begin
            passCycles <= 0;
        end else begin
            passCycles <= passCycles + 1;
            if (passCycles >= CYCLE_LIMIT) begin
                $display("timeout: a pass ran longer than %0d cycles", CYCLE_LIMIT);
                $display("CHECKS FAILED");
                $finish;
            end
        end
    end

    // Galois form with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrStep(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    task automatic buildTable();
        wordT previous;
        wordT current;
        wordT next;
        wordT lastTerm;
        int   randomDelay;
        previous = 16'd0;
        current  = 16'd1;
        // first ten Fibonacci terms
        for (int i = 0; i < 10; i++) begin
            expectedValue[i] = current;
            next     = current + previous;
            previous = current;
            current  = next;
        end
        // logic and subtract results against the last term
        lastTerm = expectedValue[9];
        expectedValue[10] = lastTerm & 16'h000F;
        expectedValue[11] = lastTerm | 16'h0080;
        expectedValue[12] = lastTerm ^ 16'h00FF;
        expectedValue[13] = lastTerm - 16'd5;
        lfsrState = 8'd83;
        for (int i = 0; i < ROWS; i++) begin
            if (i >= 3 && i <= 6) begin
                // long holds that drain every credit
                returnDelay[i] = LONG_DELAY;
            end else if (i == 0 || i == 9 || i == 13) begin
                returnDelay[i] = 0;
            end else begin
                drawBits(3, randomDelay);
                returnDelay[i] = randomDelay;
            end
        end
    endtask

    task automatic startTest();
        testStartErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        if (errorCount == testStartErrors) begin
            testsPassed++;
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: failed", name);
        end
    endtask

    task automatic reportProblem(input string what);
        $display("problem at %0t: %s", $time, what);
        errorCount++;
    endtask

    // sample outputs as they were just before the edge
    task automatic waitEdge(output logic gotValue, output wordT value);
        @(posedge clock);
        cycleCount++;
        gotValue = outValid;
        value    = outData;
    endtask

    // returns at most one credit per cycle starting with the oldest due entry
    task automatic driveCredit();
        int dueIndex;
        dueIndex = -1;
        foreach (pendingDue[i]) begin
            if (dueIndex < 0 && pendingDue[i] <= cycleCount) begin
                dueIndex = i;
            end
        end
        if (dueIndex >= 0) begin
            pendingDue.delete(dueIndex);
            creditReturn <= 1'b1;
            creditsReturned++;
        end else begin
            creditReturn <= 1'b0;
        end
    endtask

    task automatic checkIdle();
        if (outValid !== 1'b0 || halted !== 1'b0) begin
            $display("ERROR @ %0t: outValid=%b halted=%b around reset, expected both 0",
                $time, outValid, halted);
            errorCount++;
        end
    endtask

    task automatic applyReset(input int passIndex);
        logic gotValue;
        wordT value;
        startTest();
        reset        <= 1'b1;
        creditReturn <= 1'b0;
        // consumer side starts over as well
        pendingDue.delete();
        valuesSeen      = 0;
        creditsReturned = 0;
        for (int i = 0; i < 4; i++) begin
            waitEdge(gotValue, value);
            // first edge still shows the state from before reset
            if (i > 0) begin
                checkIdle();
            end
        end
        reset <= 1'b0;
        waitEdge(gotValue, value);
        checkIdle();
        endTest($sformatf("pass %0d reset", passIndex));
    endtask

    task automatic runTable(input int passIndex, input int rowLimit, input logic checkHalt);
        int   row;
        int   waitCycles;
        int   extraValues;
        int   haltDrops;
        logic stopped;
        logic gotValue;
        wordT value;
        row     = 0;
        stopped = 1'b0;
        while (row < rowLimit && !stopped) begin
            waitEdge(gotValue, value);
            if (gotValue) begin
                startTest();
                valuesSeen++;
                if (valuesSeen > creditsReturned + `OUT_CREDITS) begin
                    reportProblem("a value arrived with no credit left for it");
                end
                // every pass starts again from row 1 of the same table
                if (value !== expectedValue[row]) begin
                    $display("ERROR @ %0t: pass %0d row %0d expected %h got %h",
                        $time, passIndex, row + 1, expectedValue[row], value);
                    errorCount++;
                end
                pendingDue.push_back(cycleCount + returnDelay[row]);
                endTest($sformatf("pass %0d row %2d value %h delay %0d",
                    passIndex, row + 1, value, returnDelay[row]));
                row++;
            end else if (halted === 1'b1) begin
                reportProblem($sformatf("halted with only %0d of %0d values out", row, rowLimit));
                stopped = 1'b1;
            end
            driveCredit();
        end
        if (checkHalt) begin
            startTest();
            waitCycles  = 0;
            extraValues = 0;
            haltDrops   = 0;
            while (halted !== 1'b1 && waitCycles < HALT_WAIT) begin
                waitEdge(gotValue, value);
                if (gotValue) begin
                    extraValues++;
                end
                driveCredit();
                waitCycles++;
            end
            if (halted !== 1'b1) begin
                reportProblem("halted never rose after the last value");
            end
            // credits keep flowing back and still nothing may come out
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                waitEdge(gotValue, value);
                if (gotValue) begin
                    extraValues++;
                end
                if (halted !== 1'b1) begin
                    haltDrops++;
                end
                driveCredit();
            end
            if (extraValues != 0) begin
                reportProblem($sformatf("%0d extra values came out after the last row", extraValues));
            end
            if (haltDrops != 0) begin
                reportProblem($sformatf("halted was low for %0d cycles after halt", haltDrops));
            end
            endTest($sformatf("pass %0d halt", passIndex));
        end
    endtask

    initial begin
        clock        = 1'b0;
        reset        <= 1'b1;
        creditReturn <= 1'b0;
        cycleCount   = 0;
        errorCount   = 0;
        testsPassed  = 0;
        testsFailed  = 0;
        buildTable();
        // full run, then a run cut short by reset, then a full rerun
        applyReset(1);
        runTable(1, ROWS, 1'b1);
        applyReset(2);
        runTable(2, 6, 1'b0);
        applyReset(3);
        runTable(3, ROWS, 1'b1);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
            testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tinyCpu.f */
+incdir+hw
hw/isaPkg.sv
hw/corePkg.sv
hw/instructionRom.sv
hw/instructionDecoder.sv
hw/registerFile.sv
hw/alu.sv
hw/creditPort.sv
hw/fetchControl.sv
hw/tinyCpu.sv
tb/tinyCpuTb.sv
